/* src/unpack_pkg.sv */
package unpack_pkg;

   // data path
   localparam int unsigned IN_W  = 32;
   localparam int unsigned OUT_W = 16;   // also the widest legal field
   localparam int unsigned WID_W = 5;    // 1..16 legal
   localparam int unsigned ACC_W = 6;    // holds 0..IN_W

   // fifo depths
   localparam int unsigned IN_DEPTH  = 4;
   localparam int unsigned OUT_DEPTH = 8;

   // configuration port
   localparam int unsigned CNT_W      = 16;
   localparam int unsigned CFG_DATA_W = 16;
   localparam int unsigned ADDR_W     = 2;

   // width after reset
   localparam logic [WID_W-1:0] WIDTH_RST = 5'd8;

   // register map
   localparam logic [ADDR_W-1:0] ADDR_WIDTH  = 2'd0;   // rw
   localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd1;   // write clears error
   localparam logic [ADDR_W-1:0] ADDR_COUNT  = 2'd2;   // ro, wraps

   // fifo payloads
   typedef logic [IN_W-1:0]  in_word_t;
   typedef logic [OUT_W-1:0] out_field_t;

endpackage

/* src/unpack_fifo.sv */
module unpack_fifo #(
   parameter type         payload_t = logic [7:0],
   parameter int unsigned DEPTH     = 4
) (
   input  logic     clk_i,
   input  logic     arst_n_i,

   input  logic     wr_i,
   input  payload_t wdata_i,
   output logic     full_o,

   input  logic     rd_i,
   output payload_t rdata_o,
   output logic     empty_o
);

   payload_t                   mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(DEPTH+1)-1:0] count_q;

   logic do_wr;
   logic do_rd;

   assign full_o  = (count_q == DEPTH);
   assign empty_o = (count_q == '0);

   // strobes against the wrong level are dropped here
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   assign rdata_o = mem[rd_ptr_q];   // head shows without a read

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
      end else if (do_wr) begin
         wr_ptr_q <= (wr_ptr_q == DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ptr_q <= '0;
      end else if (do_rd) begin
         rd_ptr_q <= (rd_ptr_q == DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      end
   end

   // occupancy
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;   // idle or both
         endcase
      end
   end

endmodule

/* src/unpack_cfg_regs.sv */
module unpack_cfg_regs (
   input  logic                               clk_i,
   input  logic                               arst_n_i,

   input  logic                               cfg_we_i,
   input  logic [unpack_pkg::ADDR_W-1:0]      cfg_addr_i,
   input  logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_wdata_i,
   output logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_rdata_o,

   input  logic                               field_stb_i,
   output logic [unpack_pkg::WID_W-1:0]       width_o,
   output logic                               err_o
);

   logic [unpack_pkg::WID_W-1:0] width_q;
   logic                         err_q;
   logic [unpack_pkg::CNT_W-1:0] cnt_q;

   logic wr_width;
   logic width_bad;

   assign wr_width  = cfg_we_i && (cfg_addr_i == unpack_pkg::ADDR_WIDTH);
   assign width_bad = (cfg_wdata_i == '0) || (cfg_wdata_i > unpack_pkg::OUT_W);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         width_q <= unpack_pkg::WIDTH_RST;
      end else if (wr_width && !width_bad) begin
         width_q <= cfg_wdata_i[unpack_pkg::WID_W-1:0];
      end
   end

   // sticky until cleared through the status address
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else if (wr_width && width_bad) begin
         err_q <= 1'b1;
      end else if (cfg_we_i && (cfg_addr_i == unpack_pkg::ADDR_STATUS)) begin
         err_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (field_stb_i) begin
         cnt_q <= cnt_q + 1'b1;   // wraps
      end
   end

   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_addr_i)
         unpack_pkg::ADDR_WIDTH:  cfg_rdata_o[unpack_pkg::WID_W-1:0] = width_q;
         unpack_pkg::ADDR_STATUS: cfg_rdata_o[0] = err_q;
         unpack_pkg::ADDR_COUNT:  cfg_rdata_o[unpack_pkg::CNT_W-1:0] = cnt_q;
         default:                 cfg_rdata_o = '0;
      endcase
   end

   assign width_o = width_q;
   assign err_o   = err_q;

endmodule

/* src/bit_unpacker.sv */
module bit_unpacker (
   input  logic                          clk_i,
   input  logic                          arst_n_i,

   input  logic [unpack_pkg::WID_W-1:0]  width_i,

   // input fifo, first word fall through
   input  unpack_pkg::in_word_t          src_data_i,
   input  logic                          src_empty_i,
   output logic                          src_rd_o,

   // output fifo
   output unpack_pkg::out_field_t        dst_data_o,
   output logic                          dst_wr_o,
   input  logic                          dst_full_i
);

   typedef enum logic {
      ST_IDLE,
      ST_LOADED
   } state_t;

   state_t                        state_q;
   state_t                        state_d;

   // word register, current field always sits at the top
   unpack_pkg::in_word_t          word_q;
   unpack_pkg::in_word_t          word_d;

   // width latched with the word
   logic [unpack_pkg::WID_W-1:0]  wid_q;
   logic [unpack_pkg::WID_W-1:0]  wid_d;

   // bits used up to the end of the current field
   logic [unpack_pkg::ACC_W-1:0]  acc_q;
   logic [unpack_pkg::ACC_W-1:0]  acc_d;

   logic [unpack_pkg::ACC_W:0]    acc_sum;
   logic                          next_fits;
   unpack_pkg::in_word_t          word_aligned;
   logic                          load;

   // would one more field still end inside the word
   assign acc_sum   = acc_q + wid_q;
   assign next_fits = (acc_sum <= unpack_pkg::IN_W);

   // top wid_q bits moved down to bit 0
   assign word_aligned = word_q >> (unpack_pkg::IN_W - wid_q);
   assign dst_data_o   = word_aligned[unpack_pkg::OUT_W-1:0];

   always_comb begin
      state_d  = state_q;
      word_d   = word_q;
      wid_d    = wid_q;
      acc_d    = acc_q;
      src_rd_o = 1'b0;
      dst_wr_o = 1'b0;
      load     = 1'b0;

      case (state_q)
         ST_IDLE: begin
            if (!src_empty_i) begin
               load = 1'b1;
            end
         end
         ST_LOADED: begin
            // a full output fifo freezes word and position
            if (!dst_full_i) begin
               dst_wr_o = 1'b1;
               if (next_fits) begin
                  word_d = word_q << wid_q;
                  acc_d  = acc_sum[unpack_pkg::ACC_W-1:0];
               end else if (!src_empty_i) begin
                  load = 1'b1;         // last field, next word already waiting
               end else begin
                  state_d = ST_IDLE;   // leftover low bits dropped
               end
            end
         end
      endcase

      // take the fifo head together with the width in force now
      if (load) begin
         src_rd_o = 1'b1;
         state_d  = ST_LOADED;
         word_d   = src_data_i;
         wid_d    = width_i;
         acc_d    = {1'b0, width_i};   // first field ends at width
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         wid_q   <= '0;
         acc_q   <= '0;
      end else begin
         state_q <= state_d;
         wid_q   <= wid_d;
         acc_q   <= acc_d;
      end
   end

   always_ff @(posedge clk_i) begin
      word_q <= word_d;
   end

endmodule

/* src/unpack_top.sv */
module unpack_top (
   input  logic                               clk_i,
   input  logic                               arst_n_i,

   // word input
   input  logic                               in_push_i,
   input  unpack_pkg::in_word_t               in_data_i,
   output logic                               in_full_o,

   // field output
   input  logic                               out_pop_i,
   output unpack_pkg::out_field_t             out_data_o,
   output logic                               out_empty_o,

   // configuration
   input  logic                               cfg_we_i,
   input  logic [unpack_pkg::ADDR_W-1:0]      cfg_addr_i,
   input  logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_wdata_i,
   output logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_rdata_o,
   output logic                               cfg_err_o
);

   unpack_pkg::in_word_t         src_data;
   logic                         src_empty;
   logic                         src_rd;

   unpack_pkg::out_field_t       dst_data;
   logic                         dst_wr;   // doubles as field strobe
   logic                         dst_full;

   logic [unpack_pkg::WID_W-1:0] width;

   unpack_fifo #(
      .payload_t(unpack_pkg::in_word_t),
      .DEPTH    (unpack_pkg::IN_DEPTH)
   ) u_in_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .wr_i    (in_push_i),
      .wdata_i (in_data_i),
      .full_o  (in_full_o),
      .rd_i    (src_rd),
      .rdata_o (src_data),
      .empty_o (src_empty)
   );

   bit_unpacker u_unpacker (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .width_i    (width),
      .src_data_i (src_data),
      .src_empty_i(src_empty),
      .src_rd_o   (src_rd),
      .dst_data_o (dst_data),
      .dst_wr_o   (dst_wr),
      .dst_full_i (dst_full)
   );

   unpack_fifo #(
      .payload_t(unpack_pkg::out_field_t),
      .DEPTH    (unpack_pkg::OUT_DEPTH)
   ) u_out_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .wr_i    (dst_wr),
      .wdata_i (dst_data),
      .full_o  (dst_full),
      .rd_i    (out_pop_i),
      .rdata_o (out_data_o),
      .empty_o (out_empty_o)
   );

   unpack_cfg_regs u_cfg_regs (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_wdata_i(cfg_wdata_i),
      .cfg_rdata_o(cfg_rdata_o),
      .field_stb_i(dst_wr),
      .width_o    (width),
      .err_o      (cfg_err_o)
   );

endmodule

/* verification/unpack_properties.sv */
module unpack_properties (
   input logic clk_i,
   input logic arst_n_i,
   input logic in_push_i,
   input logic in_full_i,
   input logic src_rd_i,
   input logic src_empty_i,
   input logic dst_wr_i,
   input logic dst_full_i,
   input logic out_pop_i,
   input logic out_empty_i
);

   a_in_wr: assert property (@(posedge clk_i) disable iff (!arst_n_i) in_push_i |-> !in_full_i)
      else $error("push into the full input fifo");

   a_in_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i) src_rd_i |-> !src_empty_i)
      else $error("unpacker read the empty input fifo");

   // unpacker must hold while the output fifo is full
   a_out_wr: assert property (@(posedge clk_i) disable iff (!arst_n_i) dst_wr_i |-> !dst_full_i)
      else $error("unpacker wrote the full output fifo");

   a_out_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i) out_pop_i |-> !out_empty_i)
      else $error("pop from the empty output fifo");

   a_rst: assert property (@(posedge clk_i)
      !arst_n_i |-> !(in_push_i || src_rd_i || dst_wr_i || out_pop_i))
      else $error("strobe high during reset");

endmodule

bind unpack_top unpack_properties u_props (
   .clk_i      (clk_i),
   .arst_n_i   (arst_n_i),
   .in_push_i  (in_push_i),
   .in_full_i  (in_full_o),
   .src_rd_i   (src_rd),
   .src_empty_i(src_empty),
   .dst_wr_i   (dst_wr),
   .dst_full_i (dst_full),
   .out_pop_i  (out_pop_i),
   .out_empty_i(out_empty_o)
);

/* verification/unpack_tb.sv */
module unpack_tb;

   logic                               clk_i;
   logic                               arst_n_i;
   logic                               in_push_i;
   unpack_pkg::in_word_t               in_data_i;
   logic                               in_full_o;
   logic                               out_pop_i;
   unpack_pkg::out_field_t             out_data_o;
   logic                               out_empty_o;
   logic                               cfg_we_i;
   logic [unpack_pkg::ADDR_W-1:0]      cfg_addr_i;
   logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_wdata_i;
   logic [unpack_pkg::CFG_DATA_W-1:0]  cfg_rdata_o;
   logic                               cfg_err_o;

   // trace records; an E record keeps its field count in rec_a, its start in rec_b
   logic [7:0]  rec_kind [$];
   logic [31:0] rec_a [$];
   logic [31:0] rec_b [$];
   logic [31:0] rec_c [$];
   logic [31:0] fld_all [$];
   logic [15:0] exp_q [$];   // fields still to come out

   logic        err_exp;
   logic        done;
   logic [15:0] head;
   logic [31:0] draw;
   integer      seed;
   int          errors;
   int          checks;
   int          n_fields;
   int          limit;
   int          cycles;
   int          idx;

   unpack_top UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic add_record(input logic [7:0] kind, input logic [31:0] a, b, c);
      rec_kind.push_back(kind);
      rec_a.push_back(a);
      rec_b.push_back(b);
      rec_c.push_back(c);
   endtask

   task automatic load_trace();
      int            fd;
      int            rc;
      int            i;
      logic [63:0]   tok;
      logic [31:0]   a;
      logic [31:0]   b;
      logic [31:0]   c;
      logic [1023:0] rest;
      fd = $fopen("verification/unpack_trace.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("error: the trace file verification/unpack_trace.txt cannot be opened");
         return;
      end
      while (!$feof(fd)) begin
         tok = '0;
         rc = $fscanf(fd, "%s", tok);
         if (rc != 1) break;
         case (tok)
            "#": rc = $fgets(rest, fd);   // column notes
            "D": begin
               rc = $fscanf(fd, "%h", a);
               add_record("D", a, 0, 0);
            end
            "W": begin
               rc = $fscanf(fd, "%h %h %h", a, b, c);
               add_record("W", a, b, c);
            end
            "R": begin
               rc = $fscanf(fd, "%h %h", a, b);
               add_record("R", a, b, 0);
            end
            "E": begin
               rc = $fscanf(fd, "%h", a);
               add_record("E", a, fld_all.size(), 0);
               for (i = 0; i < a; i++) begin
                  rc = $fscanf(fd, "%h", b);
                  fld_all.push_back(b);
               end
               n_fields += a;
            end
            default: begin
               errors++;
               $display("error: the trace holds a record of unknown kind");
            end
         endcase
      end
      $fclose(fd);
   endtask

   task automatic push_word(input logic [31:0] word);
      @(negedge clk_i);
      while (in_full_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      in_push_i <= 1'b1;
      in_data_i <= word;
      @(posedge clk_i);
      in_push_i <= 1'b0;
   endtask

   // every word pushed so far has been taken and unpacked
   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk_i);
      end
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, legal);
      @(posedge clk_i);
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= addr[1:0];
      cfg_wdata_i <= data[15:0];
      @(posedge clk_i);
      cfg_we_i <= 1'b0;
      if (addr[1:0] == unpack_pkg::ADDR_STATUS) err_exp = 1'b0;
      else if (legal == 0) err_exp = 1'b1;
      @(negedge clk_i);
      check_value(cfg_err_o, err_exp, "error flag after write");
   endtask

   task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp);
      @(posedge clk_i);
      cfg_addr_i <= addr[1:0];
      @(negedge clk_i);
      check_value(cfg_rdata_o, exp, $sformatf("readback at address %0d", addr));
   endtask

   initial begin
      arst_n_i    = 1'b0;
      in_push_i   = 1'b0;
      in_data_i   = '0;
      out_pop_i   = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      err_exp     = 1'b0;
      done        = 1'b0;
      errors      = 0;
      checks      = 0;
      n_fields    = 0;
      cycles      = 0;
      load_trace();
      limit = 4 * rec_kind.size() + n_fields + 200;
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      for (idx = 0; idx < rec_kind.size(); idx++) begin
         case (rec_kind[idx])
            "D": push_word(rec_a[idx]);
            "E": for (int i = 0; i < rec_a[idx]; i++) exp_q.push_back(fld_all[rec_b[idx] + i]);
            "W": begin
               wait_drain();
               write_reg(rec_a[idx], rec_b[idx], rec_c[idx]);
            end
            default: begin
               wait_drain();
               read_reg(rec_a[idx], rec_b[idx]);
            end
         endcase
      end
      wait_drain();
      read_reg(unpack_pkg::ADDR_COUNT, n_fields % 65536);
      @(negedge clk_i);
      check_value(out_empty_o, 1'b1, "output fifo empty at the end");
      check_value(in_full_o, 1'b0, "input fifo not full at the end");
      done = 1'b1;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // consumer with random gaps, one pop every second cycle at most
   initial begin
      seed = 32'hf9455060;
      wait (arst_n_i);
      forever begin
         @(negedge clk_i);
         draw = $random(seed);
         if (!out_empty_o && draw[0]) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("error at %0t: field %h came out with none expected", $time, out_data_o);
            end else begin
               head = exp_q.pop_front();
               check_value(out_data_o, head, "output field");
            end
            @(posedge clk_i);
            out_pop_i <= 1'b1;
            @(posedge clk_i);
            out_pop_i <= 1'b0;
         end
      end
   end

   initial begin
      wait (limit != 0);
      while (!done && cycles < limit) begin
         @(posedge clk_i);
         cycles++;
      end
      if (!done) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

endmodule

/* verification/unpack_trace.txt */
# D word | E count, then the fields of the word above, msb first
# W addr data legal | R addr expected readback; all numbers hex
R 0 8
D deadbeef
E 4 de ad be ef
D 01234567
E 4 01 23 45 67
R 2 8
W 0 5 1
R 0 5
D f0e1d2c3
E 6 1e 03 10 1d 05 10
D 0000000f
E 6 00 00 00 00 00 03
W 0 7 1
R 0 7
D 12345678
E 4 09 0d 0a 67
D a5a5a5a5
E 4 52 69 34 5a
W 0 0 0
R 1 1
R 0 7
W 1 0 1
R 1 0
W 0 11 0
R 0 7
W 1 0 1
D 80000001
E 4 40 00 00 00
W 0 c 1
R 0 c
D cafef00d
E 2 caf ef0
D 13579bdf
E 2 135 79b
W 0 10 1
R 0 10
D 0badf00d
E 2 0bad f00d
D 76543210
E 2 7654 3210
W 0 8 1
D 00ff00ff
E 4 00 ff 00 ff
D 11223344
E 4 11 22 33 44
R 2 30

/* sources.f */
src/unpack_pkg.sv
src/unpack_fifo.sv
src/unpack_cfg_regs.sv
src/bit_unpacker.sv
src/unpack_top.sv
verification/unpack_properties.sv
verification/unpack_tb.sv

/* Bender.yml */
package:
  name: unpack

sources:
  - src/unpack_pkg.sv
  - src/unpack_fifo.sv
  - src/unpack_cfg_regs.sv
  - src/bit_unpacker.sv
  - src/unpack_top.sv
  - target: test
    files:
      - verification/unpack_properties.sv
      - verification/unpack_tb.sv
